// ==== logic/bus_clock_gen.sv ====
/*
 * Generates spi_mclk and custom_srclk as registered levels plus clk-domain strobes.
 * CLK_DIV must be even and at least 4. Frames are SR_WIDTH spi_mclk periods long.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_clock_gen #(
    parameter int CLK_DIV = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      spi_mclk,
    output logic                      custom_srclk,
    output conv_bus_pkg::frame_tick_t ticks
);
    import conv_bus_pkg::*;

    localparam int HALF = CLK_DIV / 2;
    localparam int DIV_W = $clog2(CLK_DIV);
    localparam int SLOT_W = $clog2(SR_WIDTH);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(SR_WIDTH - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [DIV_W-1:0] div_next;
    logic [SLOT_W-1:0] slot_cnt;
    logic [SLOT_W-1:0] slot_next;
    logic div_wrap;

    always_comb begin
        div_wrap = (div_cnt == DIV_W'(CLK_DIV - 1));
        div_next = div_wrap ? '0 : div_cnt + 1'b1;
        // Slot advances together with the spi_mclk falling edge
        if (!div_wrap) begin
            slot_next = slot_cnt;
        end else if (slot_cnt == LAST_SLOT) begin
            slot_next = '0;
        end else begin
            slot_next = slot_cnt + 1'b1;
        end
    end

    // Output levels are registered from the next count so they track the counters exactly
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            slot_cnt <= '0;
            spi_mclk <= 1'b0;
            custom_srclk <= 1'b1;
        end else begin
            div_cnt <= div_next;
            slot_cnt <= slot_next;
            spi_mclk <= (div_next >= DIV_W'(HALF));
            custom_srclk <= (slot_next == '0);
        end
    end

    always_comb begin
        ticks.shift_tick = div_wrap;
        ticks.sample_tick = (div_cnt == DIV_W'(HALF - 1));
        ticks.frame_start = div_wrap && (slot_cnt == LAST_SLOT);
        ticks.frame_end = ticks.sample_tick && (slot_cnt == LAST_SLOT);
    end

    // Shifting and sampling sit half a bus period apart
    a_tick_apart: assert property (@(posedge clk) disable iff (reset)
        !(ticks.shift_tick && ticks.sample_tick));

endmodule

`default_nettype wire

// ==== logic/conv_bus_pkg.sv ====
/*
 * Shared widths and types for the converter board control bus.
 * SR_WIDTH must be a power of two and at least 2*PORT_COUNT.
 */
`default_nettype none

package conv_bus_pkg;

    // Board geometry
    localparam int PORT_COUNT = 4;
    localparam int SR_WIDTH = 8;

    // clk cycles per spi_mclk period, must be even
    localparam int DEFAULT_CLK_DIV = 16;

    // Port number, 0 to PORT_COUNT-1
    typedef logic [1:0] port_id_t;

    // One bit per port
    typedef logic [PORT_COUNT-1:0] port_mask_t;

    // One serial frame word, sent and received MSB first
    typedef logic [SR_WIDTH-1:0] sr_word_t;

    // ADC overflow bits, MSB first: R3 L3 R2 L2 R1 L1 R0 L0
    typedef logic [7:0] ovf_t;

    // Single-cycle strobes decoded from the bus clock counters
    typedef struct packed {
        // Cycle before spi_mclk falls
        logic shift_tick;
        // Cycle before spi_mclk rises
        logic sample_tick;
        // Shift tick that enters slot 0
        logic frame_start;
        // Sample tick of the last slot
        logic frame_end;
    } frame_tick_t;

    // Words loaded into the outgoing shift registers
    typedef struct packed {
        sr_word_t adc_cs;
        sr_word_t dac_cs;
        sr_word_t clksel;
    } out_frame_t;

    // Parallel status captured from the board
    typedef struct packed {
        ovf_t aovf;
        // 1 means 8 channels, 0 means 2 channels
        port_mask_t num_channels;
        // 1 means ADC, 0 means DAC
        port_mask_t direction;
    } board_status_t;

endpackage

`default_nettype wire

// ==== logic/conv_bus_top.sv ====
/*
 * Serial control bus to the isolated converter board.
 * Everything runs on clk; spi_mclk and custom_srclk are output levels only.
 */
`timescale 1ns/10ps
`default_nettype none

module conv_bus_top #(
    parameter int CLK_DIV = conv_bus_pkg::DEFAULT_CLK_DIV
) (
    input  logic                        clk,
    input  logic                        reset,
    // Host side
    input  conv_bus_pkg::port_id_t      spi_port_id,
    input  logic                        spi_direction,
    input  conv_bus_pkg::port_mask_t    clksel,
    // Serial inputs from the board
    input  logic                        custom_adc_ovf,
    input  logic                        custom_dirchan,
    // Serial outputs to the board
    output logic                        spi_mclk,
    output logic                        spi_adc_mclk,
    output logic                        spi_dac_mclk,
    output logic                        custom_srclk,
    output logic                        spi_adc_cs,
    output logic                        spi_dac_cs,
    output logic                        custom_clksel,
    // Parallel status
    output conv_bus_pkg::board_status_t status,
    output logic                        status_valid
);
    import conv_bus_pkg::*;

    frame_tick_t ticks;
    out_frame_t next_frame;

    // ADC and DAC sides share one SPI clock
    assign spi_adc_mclk = spi_mclk;
    assign spi_dac_mclk = spi_mclk;

    bus_clock_gen #(
        .CLK_DIV(CLK_DIV)
    ) bus_clock_gen_i (
        .clk(clk),
        .reset(reset),
        .spi_mclk(spi_mclk),
        .custom_srclk(custom_srclk),
        .ticks(ticks)
    );

    select_encoder select_encoder_i (
        .clk(clk),
        .reset(reset),
        .ticks(ticks),
        .spi_port_id(spi_port_id),
        .spi_direction(spi_direction),
        .clksel(clksel),
        .next_frame(next_frame)
    );

    frame_serializer frame_serializer_i (
        .clk(clk),
        .reset(reset),
        .ticks(ticks),
        .next_frame(next_frame),
        .spi_adc_cs(spi_adc_cs),
        .spi_dac_cs(spi_dac_cs),
        .custom_clksel(custom_clksel)
    );

    frame_deserializer frame_deserializer_i (
        .clk(clk),
        .reset(reset),
        .ticks(ticks),
        .custom_adc_ovf(custom_adc_ovf),
        .custom_dirchan(custom_dirchan),
        .status(status),
        .status_valid(status_valid)
    );

endmodule

`default_nettype wire

// ==== logic/frame_deserializer.sv ====
/*
 * Assembles the overflow and direction/channel words from the board.
 * The first bit of a frame becomes the MSB. status holds until the next frame end.
 */
`timescale 1ns/10ps
`default_nettype none

module frame_deserializer (
    input  logic                        clk,
    input  logic                        reset,
    input  conv_bus_pkg::frame_tick_t   ticks,
    input  logic                        custom_adc_ovf,
    input  logic                        custom_dirchan,
    output conv_bus_pkg::board_status_t status,
    output logic                        status_valid
);
    import conv_bus_pkg::*;

    sr_word_t ovf_shreg;
    sr_word_t dirchan_shreg;
    sr_word_t ovf_word;
    sr_word_t dirchan_word;

    // Words including the bit sampled on this tick
    always_comb begin
        ovf_word = {ovf_shreg[SR_WIDTH-2:0], custom_adc_ovf};
        dirchan_word = {dirchan_shreg[SR_WIDTH-2:0], custom_dirchan};
    end

    // Input shift registers, sampled just before spi_mclk rises
    always_ff @(posedge clk) begin
        if (ticks.sample_tick) begin
            ovf_shreg <= ovf_word;
            dirchan_shreg <= dirchan_word;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status <= '0;
            status_valid <= 1'b0;
        end else begin
            status_valid <= ticks.frame_end;
            if (ticks.frame_end) begin
                status.aovf <= ovf_t'(ovf_word);
                // High nibble is channel count, low nibble is direction
                status.num_channels <= dirchan_word[2*PORT_COUNT-1:PORT_COUNT];
                status.direction <= dirchan_word[PORT_COUNT-1:0];
            end
        end
    end

    // The capture must use the last sampled bit of the frame
    a_end_on_sample: assert property (@(posedge clk) disable iff (reset)
        ticks.frame_end |-> ticks.sample_tick);

endmodule

`default_nettype wire

// ==== logic/frame_serializer.sv ====
/*
 * Shifts the staged words out MSB first, one bit per spi_mclk period.
 * Pins stay low after reset until the first frame_start loads real words.
 */
`timescale 1ns/10ps
`default_nettype none

module frame_serializer (
    input  logic                      clk,
    input  logic                      reset,
    input  conv_bus_pkg::frame_tick_t ticks,
    input  conv_bus_pkg::out_frame_t  next_frame,
    output logic                      spi_adc_cs,
    output logic                      spi_dac_cs,
    output logic                      custom_clksel
);
    import conv_bus_pkg::*;

    // All three shift registers, one per field
    out_frame_t shreg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shreg <= '0;
        end else if (ticks.frame_start) begin
            shreg <= next_frame;
        end else if (ticks.shift_tick) begin
            // Zeros trail in behind the last bit
            shreg.adc_cs <= {shreg.adc_cs[SR_WIDTH-2:0], 1'b0};
            shreg.dac_cs <= {shreg.dac_cs[SR_WIDTH-2:0], 1'b0};
            shreg.clksel <= {shreg.clksel[SR_WIDTH-2:0], 1'b0};
        end
    end

    // Pins come straight from flops, so they change only at spi_mclk falling edges
    always_comb begin
        spi_adc_cs = shreg.adc_cs[SR_WIDTH-1];
        spi_dac_cs = shreg.dac_cs[SR_WIDTH-1];
        custom_clksel = shreg.clksel[SR_WIDTH-1];
    end

    // A frame load must land on a falling edge of spi_mclk or the bit timing slips
    a_start_on_shift: assert property (@(posedge clk) disable iff (reset)
        ticks.frame_start |-> ticks.shift_tick);

endmodule

`default_nettype wire

// ==== logic/select_encoder.sv ====
/*
 * Stages chip-select and clock-select words for the next frame.
 * Inputs are sampled once per frame, on frame_end; changes mid-frame are ignored.
 */
`timescale 1ns/10ps
`default_nettype none

module select_encoder (
    input  logic                      clk,
    input  logic                      reset,
    input  conv_bus_pkg::frame_tick_t ticks,
    input  conv_bus_pkg::port_id_t    spi_port_id,
    input  logic                      spi_direction,
    input  conv_bus_pkg::port_mask_t  clksel,
    output conv_bus_pkg::out_frame_t  next_frame
);
    import conv_bus_pkg::*;

    port_mask_t port_onehot;
    out_frame_t frame_d;

    // One-hot select of the addressed port
    always_comb begin
        port_onehot = port_mask_t'(1) << spi_port_id;
    end

    // Direction picks which side the select goes to; the other side stays idle
    always_comb begin
        frame_d.adc_cs = '0;
        frame_d.dac_cs = '0;
        if (spi_direction) begin
            frame_d.adc_cs = sr_word_t'(port_onehot);
        end else begin
            frame_d.dac_cs = sr_word_t'(port_onehot);
        end
        // Upper nibble unused by the board
        frame_d.clksel = sr_word_t'(clksel);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            next_frame <= '0;
        end else if (ticks.frame_end) begin
            next_frame <= frame_d;
        end
    end

    // Never select an ADC and a DAC in the same frame, nor two ports
    a_single_select: assert property (@(posedge clk) disable iff (reset)
        $onehot0({next_frame.adc_cs, next_frame.dac_cs}));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the converter bus testbench with Verilator and runs it.
# The result is taken from the simulation log.

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

verilator --binary --timing --assert -f sim.f --top-module conv_bus_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vconv_bus_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

// ==== sim.f ====
logic/conv_bus_pkg.sv
logic/bus_clock_gen.sv
logic/select_encoder.sv
logic/frame_serializer.sv
logic/frame_deserializer.sv
logic/conv_bus_top.sv
tests/conv_bus_tb.sv

// ==== tests/conv_bus_tb.sv ====
/*
 * Testbench for conv_bus_top at the default CLK_DIV, with a serial model of the board.
 * Host inputs change only just after custom_srclk rises, so each frame carries one setting.
 */
`timescale 1ns/10ps
`default_nettype none

module conv_bus_tb;
    import conv_bus_pkg::*;

    localparam int CLK_HALF = 50;
    localparam int DRIVE_DELAY = 5;
    localparam int FRAME_CLKS = DEFAULT_CLK_DIV * SR_WIDTH;
    localparam int NUM_FRAMES = 40;
    localparam int SELECT_FRAMES = 10;
    localparam int CLKSEL_FRAMES = 25;
    // Full run plus roughly seven frames of margin
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CLKS + 880;
    localparam int RAND_SEED = 32'h245952cb;

    logic clk;
    logic reset;
    port_id_t spi_port_id;
    logic spi_direction;
    port_mask_t clksel;
    logic custom_adc_ovf;
    logic custom_dirchan;
    logic spi_mclk;
    logic spi_adc_mclk;
    logic spi_dac_mclk;
    logic custom_srclk;
    logic spi_adc_cs;
    logic spi_dac_cs;
    logic custom_clksel;
    board_status_t status;
    logic status_valid;

    // Edge tracking of the two bus clocks
    logic prev_mclk, prev_srclk;
    logic mclk_rise_evt, mclk_fall_evt, sr_rise_evt, sr_fall_evt;
    int mclk_gap, mclk_period, mclk_high_cnt, mclk_high_len, mclk_rises;
    int sr_gap, sr_period, sr_high_cnt, sr_high_len, sr_rises, sr_falls;

    // Collected outgoing words and what they should be
    sr_word_t col_adc, col_dac, col_clk;
    sr_word_t exp_adc, exp_dac, exp_clk;
    int col_bits, word_checks;
    logic word_done, exp_from_inputs;
    logic [2:0] exp_combo;
    logic [7:0] combos_hit;

    // Board side words, shifted out MSB first
    ovf_t sent_ovf;
    sr_word_t sent_dirchan, ovf_out, dirchan_out;
    int sv_gap, sv_period, sv_pulses;
    logic sv_evt;

    int frames_started, steps, cycle_cnt, total_errs;
    int reset_errs = 0;
    int clock_errs = 0;
    int select_errs = 0;
    int clksel_errs = 0;
    int status_errs = 0;
    int other_errs = 0;

    conv_bus_top conv_bus_top_i (
        .clk(clk),
        .reset(reset),
        .spi_port_id(spi_port_id),
        .spi_direction(spi_direction),
        .clksel(clksel),
        .custom_adc_ovf(custom_adc_ovf),
        .custom_dirchan(custom_dirchan),
        .spi_mclk(spi_mclk),
        .spi_adc_mclk(spi_adc_mclk),
        .spi_dac_mclk(spi_dac_mclk),
        .custom_srclk(custom_srclk),
        .spi_adc_cs(spi_adc_cs),
        .spi_dac_cs(spi_dac_cs),
        .custom_clksel(custom_clksel),
        .status(status),
        .status_valid(status_valid)
    );

    always #CLK_HALF clk = ~clk;

    // One-hot port bit, or nothing when this side is not the selected one
    function automatic sr_word_t select_word(input port_id_t port, input logic active);
        sr_word_t w;
        w = active ? (sr_word_t'(1) << port) : '0;
        return w;
    endfunction

    // Walk all eight port and direction pairs first, then go random
    task automatic pick_inputs();
        if (frames_started < 8) begin
            {spi_direction, spi_port_id} = 3'(frames_started);
        end else begin
            {spi_direction, spi_port_id} = 3'($urandom);
        end
        clksel = port_mask_t'($urandom);
    endtask

    task automatic load_board_words();
        sent_ovf = ovf_t'($urandom);
        sent_dirchan = sr_word_t'($urandom);
        ovf_out = sent_ovf;
        dirchan_out = sent_dirchan;
    endtask

    // Runs once per clk just after the edge: measures, collects, drives
    task automatic bus_step();
        mclk_rise_evt = spi_mclk && !prev_mclk;
        mclk_fall_evt = !spi_mclk && prev_mclk;
        sr_rise_evt = custom_srclk && !prev_srclk;
        sr_fall_evt = !custom_srclk && prev_srclk;
        prev_mclk = spi_mclk;
        prev_srclk = custom_srclk;
        mclk_gap++;
        sr_gap++;
        sv_gap++;
        mclk_high_cnt += int'(spi_mclk);
        sr_high_cnt += int'(custom_srclk);
        if (mclk_rise_evt) begin
            mclk_period = mclk_gap;
            mclk_gap = 0;
            mclk_rises++;
        end
        if (mclk_fall_evt) begin
            mclk_high_len = mclk_high_cnt;
            mclk_high_cnt = 0;
        end
        if (sr_rise_evt) begin
            sr_period = sr_gap;
            sr_gap = 0;
            sr_rises++;
        end
        if (sr_fall_evt) begin
            sr_high_len = sr_high_cnt;
            sr_high_cnt = 0;
            sr_falls++;
        end
        word_done = 1'b0;
        if (mclk_rise_evt) begin
            // Slot 0 carries the MSB
            if (custom_srclk) begin
                col_bits = 0;
            end
            col_adc = {col_adc[SR_WIDTH-2:0], spi_adc_cs};
            col_dac = {col_dac[SR_WIDTH-2:0], spi_dac_cs};
            col_clk = {col_clk[SR_WIDTH-2:0], custom_clksel};
            col_bits++;
            word_done = (col_bits == SR_WIDTH);
        end
        if (word_done) begin
            word_checks++;
            if (exp_from_inputs) begin
                combos_hit[exp_combo] = 1'b1;
            end
        end
        sv_evt = status_valid;
        if (status_valid) begin
            sv_period = sv_gap;
            sv_gap = 0;
            sv_pulses++;
        end
        if (sr_rise_evt) begin
            frames_started++;
            // Inputs held through the frame that just ended go out in this one
            exp_adc = select_word(spi_port_id, spi_direction);
            exp_dac = select_word(spi_port_id, !spi_direction);
            exp_clk = {4'b0000, clksel};
            exp_combo = {spi_direction, spi_port_id};
            exp_from_inputs = 1'b1;
            pick_inputs();
            load_board_words();
        end else if (mclk_fall_evt) begin
            ovf_out = {ovf_out[SR_WIDTH-2:0], 1'b0};
            dirchan_out = {dirchan_out[SR_WIDTH-2:0], 1'b0};
        end
        custom_adc_ovf = ovf_out[SR_WIDTH-1];
        custom_dirchan = dirchan_out[SR_WIDTH-1];
    endtask

    reset_levels: assert property (@(posedge clk)
        $past(reset) |-> (!spi_mclk && !spi_adc_cs && !spi_dac_cs && !custom_clksel
            && !status_valid && custom_srclk))
        else begin
            reset_errs++;
            $display("MISMATCH %t: pins are not at their reset levels", $time);
        end

    mclk_copies: assert property (@(posedge clk)
        spi_adc_mclk == spi_mclk && spi_dac_mclk == spi_mclk)
        else begin
            clock_errs++;
            $display("MISMATCH %t: ADC or DAC clock differs from spi_mclk", $time);
        end

    mclk_period_ok: assert property (@(posedge clk) disable iff (reset)
        (mclk_rise_evt && mclk_rises > 1) |-> mclk_period == DEFAULT_CLK_DIV)
        else begin
            clock_errs++;
            $display("MISMATCH %t: spi_mclk period %0d clk", $time, mclk_period);
        end

    mclk_high_ok: assert property (@(posedge clk) disable iff (reset)
        mclk_fall_evt |-> mclk_high_len == DEFAULT_CLK_DIV / 2)
        else begin
            clock_errs++;
            $display("MISMATCH %t: spi_mclk high for %0d clk", $time, mclk_high_len);
        end

    srclk_period_ok: assert property (@(posedge clk) disable iff (reset)
        (sr_rise_evt && sr_rises > 1) |-> sr_period == FRAME_CLKS)
        else begin
            clock_errs++;
            $display("MISMATCH %t: custom_srclk period %0d clk", $time, sr_period);
        end

    srclk_high_ok: assert property (@(posedge clk) disable iff (reset)
        (sr_fall_evt && sr_falls > 1) |-> sr_high_len == DEFAULT_CLK_DIV)
        else begin
            clock_errs++;
            $display("MISMATCH %t: custom_srclk high for %0d clk", $time, sr_high_len);
        end

    adc_cs_word: assert property (@(posedge clk) disable iff (reset)
        word_done |-> col_adc == exp_adc)
        else begin
            select_errs++;
            $display("MISMATCH %t: adc_cs word %h, expected %h", $time, col_adc, exp_adc);
        end

    dac_cs_word: assert property (@(posedge clk) disable iff (reset)
        word_done |-> col_dac == exp_dac)
        else begin
            select_errs++;
            $display("MISMATCH %t: dac_cs word %h, expected %h", $time, col_dac, exp_dac);
        end

    clksel_word: assert property (@(posedge clk) disable iff (reset)
        word_done |-> col_clk == exp_clk)
        else begin
            clksel_errs++;
            $display("MISMATCH %t: clksel word %h, expected %h", $time, col_clk, exp_clk);
        end

    status_word: assert property (@(posedge clk) disable iff (reset)
        status_valid |-> (status.aovf == sent_ovf && status.num_channels == sent_dirchan[7:4]
            && status.direction == sent_dirchan[3:0]))
        else begin
            status_errs++;
            $display("MISMATCH %t: status %h, expected ovf %h dirchan %h",
                $time, status, sent_ovf, sent_dirchan);
        end

    status_single: assert property (@(posedge clk) disable iff (reset)
        status_valid |=> !status_valid)
        else begin
            status_errs++;
            $display("MISMATCH %t: status_valid longer than one cycle", $time);
        end

    status_period: assert property (@(posedge clk) disable iff (reset)
        (sv_evt && sv_pulses > 1) |-> sv_period == FRAME_CLKS)
        else begin
            status_errs++;
            $display("MISMATCH %t: status_valid %0d clk after the last one", $time, sv_period);
        end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(RAND_SEED));
        clk = 1'b0;
        reset = 1'b1;
        spi_port_id = '0;
        spi_direction = 1'b0;
        clksel = port_mask_t'($urandom);
        prev_mclk = 1'b0;
        prev_srclk = 1'b1;
        {mclk_gap, mclk_period, mclk_high_cnt, mclk_high_len, mclk_rises} = '0;
        {sr_gap, sr_period, sr_high_cnt, sr_high_len, sr_rises, sr_falls} = '0;
        {sv_gap, sv_period, sv_pulses, frames_started, steps, word_checks, col_bits} = '0;
        {col_adc, col_dac, col_clk, exp_adc, exp_dac, exp_clk} = '0;
        exp_from_inputs = 1'b0;
        exp_combo = '0;
        combos_hit = '0;
        load_board_words();
        custom_adc_ovf = ovf_out[SR_WIDTH-1];
        custom_dirchan = dirchan_out[SR_WIDTH-1];
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        while (frames_started <= NUM_FRAMES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            bus_step();
            steps++;
            if (steps == 2) begin
                $display("reset: done, %0d errors", reset_errs);
            end
            if (sr_rise_evt && frames_started == SELECT_FRAMES) begin
                if (combos_hit != 8'hff) begin
                    other_errs++;
                    $display("Chip-select check reached only %0d of 8 port/direction pairs",
                        $countones(combos_hit));
                end
                $display("chip selects: done, %0d words, %0d errors", word_checks, select_errs);
            end
            if (sr_rise_evt && frames_started == CLKSEL_FRAMES) begin
                $display("clock select: done, %0d words, %0d errors", word_checks, clksel_errs);
            end
        end
        repeat (2) @(posedge clk);
        $display("clocking: done, %0d spi_mclk periods, %0d errors", mclk_rises, clock_errs);
        if (sv_pulses < NUM_FRAMES) begin
            other_errs++;
            $display("Only %0d status_valid pulses were seen", sv_pulses);
        end
        $display("status: done, %0d updates, %0d errors", sv_pulses, status_errs);
        total_errs = reset_errs + clock_errs + select_errs + clksel_errs + status_errs
            + other_errs;
        $display("Summary: 5 tests, %0d frames, %0d words, %0d errors",
            frames_started, word_checks, total_errs);
        if (total_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Ends a run that stalls
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clk cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
